// ==== hw/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

    // sequencer control states
    typedef enum logic [1:0] {
        // waiting for weight writes or the first activation
        seq_idle  = 2'd0,
        // activations of the current vector are streaming in
        seq_run   = 2'd1,
        // last element seen, results are on their way out
        seq_drain = 2'd2
    } seq_state_t;

    // opcodes broadcast to the neuron lanes
    typedef enum logic [1:0] {
        // accumulator keeps its value
        mac_nop        = 2'd0,
        // accumulator takes the new product, first element of a vector
        mac_load       = 2'd1,
        // new product is added to the running sum
        mac_accumulate = 2'd2
    } mac_op_t;

endpackage

`default_nettype wire

// ==== hw/layer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer #(
    parameter int NUM_LANES = 4,
    parameter int DEPTH     = 16,
    parameter int X_WIDTH   = 8,
    localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1,
    localparam int ADDR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             w_wr,
    input  wire        [LANE_W-1:0]         w_lane,
    input  wire        [ADDR_W-1:0]         w_addr,
    input  wire signed [X_WIDTH-1:0]        w_data,
    input  wire                             x_valid,
    input  wire signed [X_WIDTH-1:0]        x_data,
    input  wire                             x_last,
    input  wire                             drain_done,
    output logic                            busy,
    output logic       [NUM_LANES-1:0]      we_vec,
    output logic       [ADDR_W-1:0]         w_addr_q,
    output logic signed [X_WIDTH-1:0]       w_data_q,
    output nn_pkg::mac_op_t                 lane_op,
    output logic signed [X_WIDTH-1:0]       lane_x,
    output logic       [ADDR_W-1:0]         lane_addr,
    output logic                            lane_last
);

    nn_pkg::seq_state_t state;

    // index of the next element and a flag once DEPTH elements were issued
    logic [ADDR_W-1:0] addr_cnt;
    logic              addr_full;
    logic              x_accept;
    logic [ADDR_W-1:0] cur_addr;

    assign busy     = (state != nn_pkg::seq_idle);
    assign x_accept = x_valid && (state != nn_pkg::seq_drain);
    // first element of a vector always goes to address 0
    assign cur_addr = (state == nn_pkg::seq_idle) ? '0 : addr_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= nn_pkg::seq_idle;
            we_vec    <= '0;
            lane_op   <= nn_pkg::mac_nop;
            lane_last <= 1'b0;
            addr_cnt  <= '0;
            addr_full <= 1'b0;
        end else begin
            we_vec    <= '0;
            lane_op   <= nn_pkg::mac_nop;
            lane_last <= 1'b0;
            case (state)
                nn_pkg::seq_idle: begin
                    // one-hot lane select, out of range lanes write nothing
                    if (w_wr) begin
                        we_vec <= NUM_LANES'(1) << w_lane;
                    end
                    if (x_valid) begin
                        lane_op   <= nn_pkg::mac_load;
                        lane_last <= x_last;
                        addr_cnt  <= ADDR_W'(1);
                        addr_full <= (DEPTH == 1);
                        state     <= x_last ? nn_pkg::seq_drain : nn_pkg::seq_run;
                    end
                end
                nn_pkg::seq_run: begin
                    if (x_valid) begin
                        // elements past DEPTH become a nop, x_last still counts
                        if (!addr_full) begin
                            lane_op   <= nn_pkg::mac_accumulate;
                            addr_cnt  <= addr_cnt + 1'b1;
                            addr_full <= (addr_cnt == ADDR_W'(DEPTH - 1));
                        end
                        lane_last <= x_last;
                        if (x_last) begin
                            state <= nn_pkg::seq_drain;
                        end
                    end
                end
                nn_pkg::seq_drain: begin
                    if (drain_done) begin
                        state <= nn_pkg::seq_idle;
                    end
                end
                default: state <= nn_pkg::seq_idle;
            endcase
        end
    end

    // write and activation payload, only qualified by we_vec and lane_op
    always_ff @(posedge clk) begin
        if (w_wr) begin
            w_addr_q <= w_addr;
            w_data_q <= w_data;
        end
        if (x_accept) begin
            lane_x    <= x_data;
            lane_addr <= cur_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/neuron_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron_lane #(
    parameter int DEPTH     = 16,
    parameter int X_WIDTH   = 8,
    parameter int ACC_WIDTH = 24,
    localparam int ADDR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          we,
    input  wire        [ADDR_W-1:0]      w_addr,
    input  wire signed [X_WIDTH-1:0]     w_data,
    input  nn_pkg::mac_op_t              op,
    input  wire signed [X_WIDTH-1:0]     x,
    input  wire        [ADDR_W-1:0]      addr,
    input  wire                          last,
    output logic signed [ACC_WIDTH-1:0]  sum,
    output logic                         sum_valid
);

    // weight storage for one neuron
    logic signed [X_WIDTH-1:0] weights [DEPTH];

    logic signed [X_WIDTH-1:0]   w_cur;
    logic signed [2*X_WIDTH-1:0] prod;
    logic signed [ACC_WIDTH-1:0] prod_ext;

    always_ff @(posedge clk) begin
        if (we) begin
            weights[w_addr] <= w_data;
        end
    end

    // weight lookup is combinational, the op register is the pipeline stage
    assign w_cur = weights[addr];
    assign prod  = w_cur * x;
    // signed to signed assignment sign extends the product
    assign prod_ext = prod;

    always_ff @(posedge clk) begin
        case (op)
            nn_pkg::mac_load:       sum <= prod_ext;
            nn_pkg::mac_accumulate: sum <= sum + prod_ext;
            default:                sum <= sum;
        endcase
    end

    // last may also come with a nop when the vector overran DEPTH
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= last;
        end
    end

endmodule

`default_nettype wire

// ==== hw/relu.sv ====
`timescale 1ns/1ps
`default_nettype none

module relu #(
    parameter int DIN_WIDTH  = 24,
    parameter int DIN_INT    = 16,
    parameter int DOUT_WIDTH = 8,
    parameter int DOUT_INT   = 4
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire signed [DIN_WIDTH-1:0]     din,
    input  wire                            din_valid,
    output logic signed [DOUT_WIDTH-1:0]   dout,
    output logic                           dout_valid
);

    // position of the binary point on each side
    localparam int DIN_POINT  = DIN_WIDTH - DIN_INT;
    localparam int DOUT_POINT = DOUT_WIDTH - DOUT_INT;

    always_ff @(posedge clk) begin
        if (reset) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    generate
        if (DIN_INT > DOUT_INT) begin : g_narrow
            always_ff @(posedge clk) begin
                if (din_valid) begin
                    if (din[DIN_WIDTH-1]) begin
                        // negative sums clamp to zero
                        dout <= '0;
                    end else if (|din[DIN_WIDTH-2:DIN_POINT+DOUT_INT-1]) begin
                        // integer part does not fit, largest positive code
                        dout <= {1'b0, {(DOUT_WIDTH-1){1'b1}}};
                    end else begin
                        // low fraction bits are dropped, truncates toward minus infinity
                        dout <= din[DIN_POINT+DOUT_INT-1 -: DOUT_WIDTH];
                    end
                end
            end
        end else begin : g_wide
            // every positive input fits, keep integer bits and the top fraction bits
            localparam int KEEP = DIN_INT + DOUT_POINT;

            always_ff @(posedge clk) begin
                if (din_valid) begin
                    if (din[DIN_WIDTH-1]) begin
                        dout <= '0;
                    end else begin
                        dout <= DOUT_WIDTH'(din[DIN_WIDTH-1 -: KEEP]);
                    end
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hw/result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_drain #(
    parameter int NUM_LANES = 4,
    parameter int Y_WIDTH   = 8,
    localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [NUM_LANES*Y_WIDTH-1:0]     act_vec,
    input  wire  [NUM_LANES-1:0]             act_valid_vec,
    output logic                             y_valid,
    output logic [LANE_W-1:0]                y_lane,
    output logic signed [Y_WIDTH-1:0]        y_data,
    output logic                             drain_done
);

    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(NUM_LANES - 1);

    // lane 0 sits in the low slice and leaves first
    logic [NUM_LANES*Y_WIDTH-1:0] shreg;
    logic [LANE_W-1:0]            lane_cnt;
    logic                         active;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            lane_cnt <= '0;
        end else if (act_valid_vec[0]) begin
            // all lanes finish in the same cycle, lane 0 stands for the rest
            active   <= 1'b1;
            lane_cnt <= '0;
        end else if (active) begin
            if (lane_cnt == LAST_LANE) begin
                active   <= 1'b0;
                lane_cnt <= '0;
            end else begin
                lane_cnt <= lane_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid_vec[0]) begin
            shreg <= act_vec;
        end else if (active) begin
            shreg <= shreg >> Y_WIDTH;
        end
    end

    assign y_valid    = active;
    assign y_lane     = lane_cnt;
    assign y_data     = shreg[Y_WIDTH-1:0];
    // one cycle pulse together with the final result
    assign drain_done = active && (lane_cnt == LAST_LANE);

endmodule

`default_nettype wire

// ==== hw/dense_layer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dense_layer_top #(
    parameter int NUM_LANES = 4,
    parameter int DEPTH     = 16,
    parameter int X_WIDTH   = 8,
    parameter int X_INT     = 4,
    parameter int ACC_WIDTH = 24,
    parameter int ACC_INT   = 16,
    parameter int Y_WIDTH   = 8,
    parameter int Y_INT     = 4,
    localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1,
    localparam int ADDR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         w_wr,
    input  wire        [LANE_W-1:0]     w_lane,
    input  wire        [ADDR_W-1:0]     w_addr,
    input  wire signed [X_WIDTH-1:0]    w_data,
    input  wire                         x_valid,
    input  wire signed [X_WIDTH-1:0]    x_data,
    input  wire                         x_last,
    output logic                        busy,
    output logic                        y_valid,
    output logic       [LANE_W-1:0]     y_lane,
    output logic signed [Y_WIDTH-1:0]   y_data
);

    // product fraction bits against the accumulator format handed to the relu
    localparam int PROD_FRAC = 2 * (X_WIDTH - X_INT);
    localparam int ACC_FRAC  = ACC_WIDTH - ACC_INT;
    localparam int SUM_SHR   = (PROD_FRAC > ACC_FRAC) ? PROD_FRAC - ACC_FRAC : 0;
    localparam int SUM_SHL   = (ACC_FRAC > PROD_FRAC) ? ACC_FRAC - PROD_FRAC : 0;

    logic       [NUM_LANES-1:0]     we_vec;
    logic       [ADDR_W-1:0]        w_addr_q;
    logic signed [X_WIDTH-1:0]      w_data_q;
    nn_pkg::mac_op_t                lane_op;
    logic signed [X_WIDTH-1:0]      lane_x;
    logic       [ADDR_W-1:0]        lane_addr;
    logic                           lane_last;
    logic [NUM_LANES*Y_WIDTH-1:0]   act_vec;
    logic [NUM_LANES-1:0]           act_valid_vec;
    logic                           drain_done;

    layer_sequencer #(
        .NUM_LANES (NUM_LANES),
        .DEPTH     (DEPTH),
        .X_WIDTH   (X_WIDTH)
    ) i_sequencer (
        .clk        (clk),
        .reset      (reset),
        .w_wr       (w_wr),
        .w_lane     (w_lane),
        .w_addr     (w_addr),
        .w_data     (w_data),
        .x_valid    (x_valid),
        .x_data     (x_data),
        .x_last     (x_last),
        .drain_done (drain_done),
        .busy       (busy),
        .we_vec     (we_vec),
        .w_addr_q   (w_addr_q),
        .w_data_q   (w_data_q),
        .lane_op    (lane_op),
        .lane_x     (lane_x),
        .lane_addr  (lane_addr),
        .lane_last  (lane_last)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic signed [ACC_WIDTH-1:0] sum;
        logic signed [ACC_WIDTH-1:0] sum_aligned;
        logic                        sum_valid;
        logic signed [Y_WIDTH-1:0]   act;

        neuron_lane #(
            .DEPTH     (DEPTH),
            .X_WIDTH   (X_WIDTH),
            .ACC_WIDTH (ACC_WIDTH)
        ) i_lane (
            .clk       (clk),
            .reset     (reset),
            .we        (we_vec[i]),
            .w_addr    (w_addr_q),
            .w_data    (w_data_q),
            .op        (lane_op),
            .x         (lane_x),
            .addr      (lane_addr),
            .last      (lane_last),
            .sum       (sum),
            .sum_valid (sum_valid)
        );

        // constant shift, no shift at all with the default formats
        assign sum_aligned = (sum >>> SUM_SHR) <<< SUM_SHL;

        relu #(
            .DIN_WIDTH  (ACC_WIDTH),
            .DIN_INT    (ACC_INT),
            .DOUT_WIDTH (Y_WIDTH),
            .DOUT_INT   (Y_INT)
        ) i_relu (
            .clk        (clk),
            .reset      (reset),
            .din        (sum_aligned),
            .din_valid  (sum_valid),
            .dout       (act),
            .dout_valid (act_valid_vec[i])
        );

        assign act_vec[i*Y_WIDTH +: Y_WIDTH] = act;
    end

    result_drain #(
        .NUM_LANES (NUM_LANES),
        .Y_WIDTH   (Y_WIDTH)
    ) i_drain (
        .clk           (clk),
        .reset         (reset),
        .act_vec       (act_vec),
        .act_valid_vec (act_valid_vec),
        .y_valid       (y_valid),
        .y_lane        (y_lane),
        .y_data        (y_data),
        .drain_done    (drain_done)
    );

endmodule

`default_nettype wire

// ==== test/dense_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dense_layer_tb;

    localparam int NUM_LANES = 4;
    localparam int DEPTH     = 16;
    localparam int MAX_WAIT  = 60;

    logic              clk;
    logic              reset;
    logic              w_wr;
    logic [1:0]        w_lane;
    logic [3:0]        w_addr;
    logic signed [7:0] w_data;
    logic              x_valid;
    logic signed [7:0] x_data;
    logic              x_last;
    wire               busy;
    wire               y_valid;
    wire  [1:0]        y_lane;
    wire signed [7:0]  y_data;

    integer seed;
    int     errors;
    int     tests_run;
    int     errors_at_start;
    // weights as the host wrote them in 4.4 format
    int     w_model [NUM_LANES][DEPTH];
    int     vec [$];
    int     exp_y [NUM_LANES];

    dense_layer_top #(
        .NUM_LANES (NUM_LANES),
        .DEPTH     (DEPTH)
    ) i_dut (
        .clk     (clk),
        .reset   (reset),
        .w_wr    (w_wr),
        .w_lane  (w_lane),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .x_valid (x_valid),
        .x_data  (x_data),
        .x_last  (x_last),
        .busy    (busy),
        .y_valid (y_valid),
        .y_lane  (y_lane),
        .y_data  (y_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic int random_in(input int limit);
        return $random(seed) % limit;
    endfunction

    // sum in 1/256 units and output in 1/16 units
    function automatic int expected_output(input int lane);
        int sum;
        sum = 0;
        foreach (vec[i]) begin
            sum += w_model[lane][i] * vec[i];
        end
        if (sum < 0) begin
            return 0;
        end
        if (sum >= 2048) begin
            return 127;
        end
        return sum >>> 4;
    endfunction

    task automatic load_weight(input int lane, input int addr, input int value);
        @(posedge clk);
        w_wr    <= 1'b1;
        w_lane  <= 2'(lane);
        w_addr  <= 4'(addr);
        w_data  <= 8'(value);
        x_valid <= 1'b0;
        x_last  <= 1'b0;
        w_model[lane][addr] = value;
    endtask

    task automatic send_vector();
        foreach (vec[i]) begin
            @(posedge clk);
            w_wr    <= 1'b0;
            x_valid <= 1'b1;
            x_data  <= 8'(vec[i]);
            x_last  <= (i == vec.size() - 1);
        end
        @(posedge clk);
        x_valid <= 1'b0;
        x_last  <= 1'b0;
    endtask

    // activations and weight writes that land while the drain runs
    task automatic inject_noise();
        for (int n = 0; n < 2; n++) begin
            @(posedge clk);
            x_valid <= 1'b1;
            x_data  <= 8'sd99;
            x_last  <= 1'b1;
            w_wr    <= 1'b1;
            w_lane  <= 2'(2 * n + 1);
            w_addr  <= 4'(n);
            w_data  <= -8'sd77;
            @(posedge clk);
            x_valid <= 1'b0;
            x_last  <= 1'b0;
            w_wr    <= 1'b0;
        end
    endtask

    // cycles counted from the edge that samples x_last
    task automatic collect_results();
        int cycles;
        int got;
        int busy_low_at;
        cycles = 0;
        got = 0;
        busy_low_at = 0;
        while ((got < NUM_LANES || busy_low_at == 0) && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
            if (y_valid && got < NUM_LANES) begin
                check_value("y_valid cycle", cycles, 4 + got);
                check_value("y_lane", y_lane, got);
                check_value($sformatf("y_data[%0d]", got), y_data, exp_y[got]);
                got++;
            end else if (y_valid) begin
                report_error("y_valid stayed high after the last lane");
            end
            if (!busy && busy_low_at == 0) begin
                busy_low_at = cycles;
            end
        end
        if (got < NUM_LANES) begin
            report_error($sformatf("only %0d of %0d results arrived", got, NUM_LANES));
        end else if (busy_low_at == 0) begin
            report_error("busy never went low after the results");
        end else begin
            check_value("busy low cycle", busy_low_at, NUM_LANES + 4);
        end
    endtask

    task automatic run_vector(input bit noisy);
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_y[l] = expected_output(l);
        end
        send_vector();
        if (noisy) begin
            fork
                collect_results();
                inject_noise();
            join
        end else begin
            collect_results();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_reset_state();
        check_value("busy", busy, 0);
        check_value("y_valid", y_valid, 0);
        load_weight(0, 0, 16);
        load_weight(1, 0, 32);
        load_weight(2, 0, 48);
        load_weight(3, 0, 5);
        vec = '{16};
        run_vector(1'b0);
        finish_test("reset state");
    endtask

    task automatic test_relu_clamp();
        // two weights per lane and lanes 0 and 3 end negative
        int w [2*NUM_LANES] = '{-16, -16, 16, 8, -128, 127, 0, -1};
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int i = 0; i < 2; i++) begin
                load_weight(l, i, w[2*l+i]);
            end
        end
        vec = '{16, 32};
        run_vector(1'b0);
        finish_test("relu clamp");
    endtask

    task automatic test_saturation();
        // lane 1 lands at 2030 and lane 3 just over the limit
        int w [2*NUM_LANES] = '{127, 127, 18, 2, 18, 1, 18, 5};
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int i = 0; i < 2; i++) begin
                load_weight(l, i, w[2*l+i]);
            end
        end
        vec = '{112, 7};
        run_vector(1'b0);
        finish_test("saturation");
    endtask

    task automatic test_random_vector();
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int a = 0; a < DEPTH; a++) begin
                load_weight(l, a, random_in(32));
            end
        end
        vec.delete();
        for (int i = 0; i < DEPTH; i++) begin
            vec.push_back(random_in(32));
        end
        run_vector(1'b0);
        finish_test("full length random vector");
    endtask

    task automatic test_busy_protection();
        vec.delete();
        for (int i = 0; i < 8; i++) begin
            vec.push_back(random_in(32));
        end
        run_vector(1'b1);
        finish_test("busy protection");
    endtask

    // lanes 1 and 3 still hold the weights of the random test
    task automatic test_back_to_back();
        for (int a = 0; a < DEPTH; a++) begin
            load_weight(2, a, random_in(64));
        end
        vec.delete();
        for (int i = 0; i < DEPTH; i++) begin
            vec.push_back(random_in(32));
        end
        run_vector(1'b0);
        finish_test("back to back vectors");
    endtask

    initial begin
        seed = 32'h4c25;
        errors = 0;
        tests_run = 0;
        errors_at_start = 0;
        reset = 1'b1;
        w_wr = 1'b0;
        w_lane = '0;
        w_addr = '0;
        w_data = '0;
        x_valid = 1'b0;
        x_data = '0;
        x_last = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_state();
        test_relu_clamp();
        test_saturation();
        test_random_vector();
        test_busy_protection();
        test_back_to_back();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/nn_pkg.sv
hw/layer_sequencer.sv
hw/neuron_lane.sv
hw/relu.sv
hw/result_drain.sv
hw/dense_layer_top.sv
test/dense_layer_tb.sv
